// ==== include/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width
`define CPU_XLEN 32

// Register file size
`define CPU_NREGS 32
`define CPU_REG_W 5

// Main memory size in words
`define CPU_MEM_DEPTH 2048

// First fetch address
`define CPU_PC_RESET 32'h0000_0000

`endif

// ==== verilog/isa_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package isa_pkg;

   typedef logic [`CPU_XLEN-1:0]  word_t;
   typedef logic [`CPU_REG_W-1:0] reg_idx_t;
   typedef logic [15:0]           imm_t;

   // Instruction type in bits 31:27
   typedef enum logic [4:0] {
      OP_NOP = 5'd0,
      OP_LDI,
      OP_LD,
      OP_ST,
      OP_ALU,
      OP_JMP
   } opcode_e;

   // ALU function in bits 2:0
   typedef enum logic [2:0] {
      FN_ADD = 3'd0,
      FN_SUB,
      FN_AND,
      FN_OR,
      FN_XOR,
      FN_SHL
   } alu_fn_e;

endpackage

`default_nettype wire

// ==== verilog/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

   import isa_pkg::*;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t ra;
      reg_idx_t rb;
      alu_fn_e  fn;
      imm_t     imm;
      logic     writes_rd;
   } decoded_t;

   // Execute to memory packet
   typedef struct packed {
      decoded_t dec;
      word_t    result;
      word_t    st_data;
      word_t    addr;
   } exe_pkt_t;

   typedef struct packed {
      logic     valid;
      reg_idx_t rd;
      word_t    data;
   } retire_t;

   typedef struct packed {
      logic  valid;
      word_t addr;
      word_t data;
   } mem_wr_t;

   typedef struct packed {
      logic  valid;
      word_t addr;
      word_t data;
   } prog_wr_t;

endpackage

`default_nettype wire

// ==== verilog/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
   input  isa_pkg::word_t     instr,
   output pipe_pkg::decoded_t dec
);

   import isa_pkg::*;

   opcode_e op;

   assign op = opcode_e'(instr[31:27]);

   always_comb begin
      dec = '0;
      case (op)
         OP_LDI, OP_LD, OP_ST, OP_ALU, OP_JMP: begin
            dec.opcode = op;
            dec.rd     = instr[26:22];
            dec.ra     = instr[21:17];
            dec.rb     = instr[16:12];
            dec.fn     = alu_fn_e'(instr[2:0]);
            // Overlaps rb, only meaningful for OP_LDI
            dec.imm    = instr[15:0];
            dec.writes_rd = (op == OP_LDI) || (op == OP_LD) || (op == OP_ALU);
         end
         // Unknown opcodes run as a nop
         default: begin
            dec = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/stall_detector.sv ====
`timescale 1ns/100ps
`default_nettype none

module stall_detector (
   input  pipe_pkg::decoded_t issue_dec,
   input  pipe_pkg::decoded_t dec_stage,
   input  pipe_pkg::decoded_t exe_stage,
   input  pipe_pkg::decoded_t mem_stage,
   output logic               stall
);

   import isa_pkg::*;
   import pipe_pkg::*;

   logic uses_ra;
   logic uses_rb;
   logic raw_hazard;
   logic jump_pending;

   // True when a later stage will still write one of our sources
   function automatic logic conflicts(decoded_t later, decoded_t cur, logic ra_on, logic rb_on);
      return later.writes_rd &&
             ((ra_on && later.rd == cur.ra) || (rb_on && later.rd == cur.rb));
   endfunction

   // LDI and NOP read nothing
   assign uses_ra = (issue_dec.opcode == OP_LD) || (issue_dec.opcode == OP_ST) ||
                    (issue_dec.opcode == OP_ALU) || (issue_dec.opcode == OP_JMP);
   assign uses_rb = (issue_dec.opcode == OP_ST) || (issue_dec.opcode == OP_ALU) ||
                    (issue_dec.opcode == OP_JMP);

   assign raw_hazard = conflicts(dec_stage, issue_dec, uses_ra, uses_rb) ||
                       conflicts(exe_stage, issue_dec, uses_ra, uses_rb) ||
                       conflicts(mem_stage, issue_dec, uses_ra, uses_rb);

   // Fetch stays frozen until the jump has left execute
   assign jump_pending = (dec_stage.opcode == OP_JMP) || (exe_stage.opcode == OP_JMP);

   assign stall = raw_hazard || jump_pending;

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module register_file (
   input  logic              clk,
   input  logic              rst,
   input  isa_pkg::reg_idx_t ra_idx,
   input  isa_pkg::reg_idx_t rb_idx,
   output isa_pkg::word_t    ra_data,
   output isa_pkg::word_t    rb_data,
   input  pipe_pkg::retire_t wr
);

   import isa_pkg::*;

   word_t regs [`CPU_NREGS];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr.valid) begin
         regs[wr.rd] <= wr.data;
      end
   end

   // Write-through so a consumer can issue during its producer's write-back
   assign ra_data = (wr.valid && wr.rd == ra_idx) ? wr.data : regs[ra_idx];
   assign rb_data = (wr.valid && wr.rd == rb_idx) ? wr.data : regs[rb_idx];

endmodule

`default_nettype wire

// ==== verilog/stage_exe.sv ====
`timescale 1ns/100ps
`default_nettype none

module stage_exe (
   input  logic               clk,
   input  logic               rst,
   input  pipe_pkg::decoded_t dec_in,
   input  isa_pkg::word_t     ra_val,
   input  isa_pkg::word_t     rb_val,
   output pipe_pkg::exe_pkt_t exe_out,
   output logic               jump_taken,
   output isa_pkg::word_t     jump_target
);

   import isa_pkg::*;

   word_t alu_res;
   word_t result;

   always_comb begin
      case (dec_in.fn)
         FN_ADD:  alu_res = ra_val + rb_val;
         FN_SUB:  alu_res = ra_val - rb_val;
         FN_AND:  alu_res = ra_val & rb_val;
         FN_OR:   alu_res = ra_val | rb_val;
         FN_XOR:  alu_res = ra_val ^ rb_val;
         FN_SHL:  alu_res = ra_val << rb_val[4:0];
         default: alu_res = '0;
      endcase
   end

   // Immediates are zero-extended
   assign result = (dec_in.opcode == OP_LDI) ? word_t'(dec_in.imm) : alu_res;

   // Register-indirect jump, taken on a nonzero condition
   assign jump_taken  = (dec_in.opcode == OP_JMP) && (ra_val != '0);
   assign jump_target = rb_val;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         exe_out <= '0;
      end else begin
         exe_out.dec     <= dec_in;
         exe_out.result  <= result;
         exe_out.st_data <= ra_val;
         // Stores address through rb, loads through ra
         exe_out.addr    <= (dec_in.opcode == OP_ST) ? rb_val : ra_val;
      end
   end

   // Only bubbles follow a jump into execute while it resolves
   a_jump_shadow: assert property (@(posedge clk) disable iff (!rst)
      (dec_in.opcode == OP_JMP) |=>
         (dec_in.opcode == OP_NOP) ##1 (dec_in.opcode == OP_NOP));

endmodule

`default_nettype wire

// ==== verilog/main_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module main_memory (
   input  logic               clk,
   input  isa_pkg::word_t     fetch_addr,
   output isa_pkg::word_t     fetch_data,
   input  isa_pkg::word_t     data_addr,
   output isa_pkg::word_t     data_rd,
   input  pipe_pkg::mem_wr_t  st,
   input  pipe_pkg::prog_wr_t prog
);

   import isa_pkg::*;

   localparam int AW = $clog2(`CPU_MEM_DEPTH);

   word_t mem [`CPU_MEM_DEPTH];

   // Word addressed, upper bits ignored
   assign fetch_data = mem[fetch_addr[AW-1:0]];
   assign data_rd    = mem[data_addr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (prog.valid) begin
         mem[prog.addr[AW-1:0]] <= prog.data;
      end else if (st.valid) begin
         mem[st.addr[AW-1:0]] <= st.data;
      end
   end

   // Loader only runs in reset, when no store can be in flight
   a_no_write_clash: assert property (@(posedge clk) !(st.valid && prog.valid));

endmodule

`default_nettype wire

// ==== verilog/cpu_pipelined_basic.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_pipelined_basic (
   input  logic               clk,
   input  logic               rst,
   input  pipe_pkg::prog_wr_t prog,
   output isa_pkg::word_t     pc,
   output pipe_pkg::retire_t  retire,
   output pipe_pkg::mem_wr_t  mem_wr
);

   import isa_pkg::*;
   import pipe_pkg::*;

   word_t    next_pc;
   word_t    fetch_data;
   word_t    issue_q;
   decoded_t issue_dec;
   word_t    ra_data;
   word_t    rb_data;
   decoded_t dec_q;
   word_t    ra_q;
   word_t    rb_q;
   exe_pkt_t exe_out;
   logic     jump_taken;
   word_t    jump_target;
   word_t    data_rd;
   decoded_t wb_dec;
   prog_wr_t prog_ld;
   logic     stall;
   logic     squash;

   // Fetch

   // A jump leaving issue freezes fetch and drops the word behind it
   assign squash = (issue_dec.opcode == OP_JMP) && !stall;

   always_comb begin
      if (jump_taken) begin
         next_pc = jump_target;
      end else if (stall || squash) begin
         next_pc = pc;
      end else begin
         next_pc = pc + word_t'(1);
      end
   end

   // PC is the fetch pipeline register
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc <= `CPU_PC_RESET;
      end else begin
         pc <= next_pc;
      end
   end

   // Issue and decode
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         issue_q <= '0;
      end else if (!stall) begin
         issue_q <= squash ? '0 : fetch_data;
      end
   end

   instr_decoder u_instr_decoder (
      .instr (issue_q),
      .dec   (issue_dec)
   );

   register_file u_register_file (
      .clk     (clk),
      .rst     (rst),
      .ra_idx  (issue_dec.ra),
      .rb_idx  (issue_dec.rb),
      .ra_data (ra_data),
      .rb_data (rb_data),
      .wr      (retire)
   );

   // Bubble into execute while stalled
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         dec_q <= '0;
      end else begin
         dec_q <= stall ? '0 : issue_dec;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         ra_q <= '0;
         rb_q <= '0;
      end else begin
         ra_q <= ra_data;
         rb_q <= rb_data;
      end
   end

   // Execute
   stage_exe u_stage_exe (
      .clk         (clk),
      .rst         (rst),
      .dec_in      (dec_q),
      .ra_val      (ra_q),
      .rb_val      (rb_q),
      .exe_out     (exe_out),
      .jump_taken  (jump_taken),
      .jump_target (jump_target)
   );

   // Memory
   assign mem_wr.valid = (exe_out.dec.opcode == OP_ST);
   assign mem_wr.addr  = exe_out.addr;
   assign mem_wr.data  = exe_out.st_data;

   always_comb begin
      prog_ld       = prog;
      prog_ld.valid = prog.valid && !rst;
   end

   main_memory u_main_memory (
      .clk        (clk),
      .fetch_addr (pc),
      .fetch_data (fetch_data),
      .data_addr  (exe_out.addr),
      .data_rd    (data_rd),
      .st         (mem_wr),
      .prog       (prog_ld)
   );

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         retire <= '0;
      end else begin
         retire.valid <= exe_out.dec.writes_rd;
         retire.rd    <= exe_out.dec.rd;
         retire.data  <= (exe_out.dec.opcode == OP_LD) ? data_rd : exe_out.result;
      end
   end

   // Write-back seen as a decoded entry for hazard checks
   always_comb begin
      wb_dec           = '0;
      wb_dec.rd        = retire.rd;
      wb_dec.writes_rd = retire.valid;
   end

   stall_detector u_stall_detector (
      .issue_dec (issue_dec),
      .dec_stage (dec_q),
      .exe_stage (exe_out.dec),
      .mem_stage (wb_dec),
      .stall     (stall)
   );

   // Hazards and jumps drain within a few cycles
   a_stall_bounded: assert property (@(posedge clk) disable iff (!rst)
      $rose(stall) |-> ##[1:8] !stall);

endmodule

`default_nettype wire

// ==== dv/tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu;

   import isa_pkg::*;
   import pipe_pkg::*;

   localparam int CLK_PERIOD       = 20;
   localparam int RESET_CYCLES     = 16;
   localparam int PROG_LEN         = RESET_CYCLES - 1;
   localparam int CYCLES_PER_INSTR = 40;
   localparam int IDLE_CYCLES      = 30;
   localparam int MODEL_STEPS      = 1000;

   typedef struct packed {
      reg_idx_t rd;
      word_t    data;
   } wb_event_t;

   typedef struct packed {
      word_t addr;
      word_t data;
   } st_event_t;

   logic     clk;
   logic     rst;
   prog_wr_t prog;
   word_t    pc;
   retire_t  retire;
   mem_wr_t  mem_wr;

   word_t     program_words [PROG_LEN];
   wb_event_t exp_retire [$];
   st_event_t exp_store [$];

   cpu_pipelined_basic u_cpu_pipelined_basic (
      .clk    (clk),
      .rst    (rst),
      .prog   (prog),
      .pc     (pc),
      .retire (retire),
      .mem_wr (mem_wr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_mismatch(string name, word_t expected, word_t actual);
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic report_failure(string what);
      $display("%0t: %s", $time, what);
      abort_run();
   endtask

   // Field layout: op 31:27, rd 26:22, ra 21:17, rb 16:12, fn 2:0
   function automatic word_t enc_reg(opcode_e op, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb,
                                     alu_fn_e fn);
      return {op, rd, ra, rb, 9'b0, fn};
   endfunction

   function automatic word_t enc_ldi(reg_idx_t rd, imm_t imm);
      return {OP_LDI, rd, 6'b0, imm};
   endfunction

   function automatic word_t enc_alu(alu_fn_e fn, reg_idx_t rd, reg_idx_t ra, reg_idx_t rb);
      return enc_reg(OP_ALU, rd, ra, rb, fn);
   endfunction

   task automatic build_program();
      imm_t addr_imm;
      imm_t val_imm;
      imm_t junk_imm;
      // Data address kept clear of the program words
      addr_imm = imm_t'(64 + ($urandom % (`CPU_MEM_DEPTH - 64)));
      val_imm  = imm_t'($urandom);
      junk_imm = imm_t'($urandom);
      program_words[0]  = enc_ldi(5'd1, addr_imm);
      program_words[1]  = enc_ldi(5'd2, val_imm);
      // Each ALU op reads the result just before it
      program_words[2]  = enc_alu(FN_ADD, 5'd3, 5'd1, 5'd2);
      program_words[3]  = enc_alu(FN_SUB, 5'd4, 5'd2, 5'd3);
      program_words[4]  = enc_alu(FN_AND, 5'd5, 5'd4, 5'd2);
      program_words[5]  = enc_alu(FN_OR,  5'd6, 5'd5, 5'd1);
      program_words[6]  = enc_alu(FN_XOR, 5'd7, 5'd6, 5'd3);
      program_words[7]  = enc_alu(FN_SHL, 5'd8, 5'd7, 5'd2);
      // Store r8 at the address in r1
      program_words[8]  = enc_reg(OP_ST, 5'd0, 5'd8, 5'd1, FN_ADD);
      program_words[9]  = enc_ldi(5'd11, 16'd14);
      // r0 is never written so this one falls through to the load
      program_words[10] = enc_reg(OP_JMP, 5'd0, 5'd0, 5'd11, FN_ADD);
      // Read the stored word back into r9
      program_words[11] = enc_reg(OP_LD, 5'd9, 5'd1, 5'd0, FN_ADD);
      program_words[12] = enc_reg(OP_JMP, 5'd0, 5'd11, 5'd11, FN_ADD);
      program_words[13] = enc_ldi(5'd12, junk_imm);
      // Jump to itself, idle from here on
      program_words[14] = enc_reg(OP_JMP, 5'd0, 5'd11, 5'd11, FN_ADD);
   endtask

   task automatic expect_retire(reg_idx_t rd, word_t data);
      wb_event_t ev;
      ev.rd   = rd;
      ev.data = data;
      exp_retire.push_back(ev);
   endtask

   task automatic expect_store(word_t addr, word_t data);
      st_event_t ev;
      ev.addr = addr;
      ev.data = data;
      exp_store.push_back(ev);
   endtask

   // Sequential ISA model, one instruction per step
   task automatic run_model();
      word_t      regs [`CPU_NREGS];
      word_t      data_mem [word_t];
      word_t      cur_pc;
      word_t      next_pc;
      word_t      instr;
      word_t      result;
      word_t      key;
      logic [4:0] op;
      reg_idx_t   rd;
      reg_idx_t   ra;
      reg_idx_t   rb;
      logic       halted;
      cur_pc = `CPU_PC_RESET;
      halted = 1'b0;
      foreach (regs[i]) regs[i] = '0;
      for (int step = 0; step < MODEL_STEPS && !halted; step++) begin
         instr   = (cur_pc < PROG_LEN) ? program_words[cur_pc] : '0;
         op      = instr[31:27];
         rd      = instr[26:22];
         ra      = instr[21:17];
         rb      = instr[16:12];
         next_pc = cur_pc + 1;
         case (op)
            OP_LDI: begin
               regs[rd] = {16'h0000, instr[15:0]};
               expect_retire(rd, regs[rd]);
            end
            OP_LD: begin
               key      = regs[ra] % `CPU_MEM_DEPTH;
               regs[rd] = data_mem.exists(key) ? data_mem[key] : '0;
               expect_retire(rd, regs[rd]);
            end
            OP_ST: begin
               key           = regs[rb] % `CPU_MEM_DEPTH;
               data_mem[key] = regs[ra];
               expect_store(regs[rb], regs[ra]);
            end
            OP_ALU: begin
               case (instr[2:0])
                  FN_ADD:  result = regs[ra] + regs[rb];
                  FN_SUB:  result = regs[ra] - regs[rb];
                  FN_AND:  result = regs[ra] & regs[rb];
                  FN_OR:   result = regs[ra] | regs[rb];
                  FN_XOR:  result = regs[ra] ^ regs[rb];
                  FN_SHL:  result = regs[ra] << regs[rb][4:0];
                  default: result = '0;
               endcase
               regs[rd] = result;
               expect_retire(rd, result);
            end
            OP_JMP: begin
               if (regs[ra] != '0) begin
                  halted  = (regs[rb] == cur_pc);
                  next_pc = regs[rb];
               end
            end
            default: begin
            end
         endcase
         cur_pc = next_pc;
      end
   endtask

   task automatic load_program();
      for (int cyc = 0; cyc < RESET_CYCLES - 1; cyc++) begin
         @(posedge clk);
         prog.valid <= 1'b1;
         prog.addr  <= word_t'(cyc);
         prog.data  <= program_words[cyc];
      end
      @(posedge clk);
      prog <= '0;
      rst  <= 1'b1;
   endtask

   task automatic check_retire();
      wb_event_t exp;
      if (exp_retire.size() == 0) begin
         report_failure($sformatf("write-back to r%0d with no instruction left to retire",
                                  retire.rd));
      end else begin
         exp = exp_retire.pop_front();
         assert (retire.rd == exp.rd && retire.data == exp.data) else begin
            if (retire.rd != exp.rd)
               report_mismatch("retire.rd", word_t'(exp.rd), word_t'(retire.rd));
            else
               report_mismatch("retire.data", exp.data, retire.data);
         end
      end
   endtask

   task automatic check_store();
      st_event_t exp;
      if (exp_store.size() == 0) begin
         report_failure("memory write with no store left in the program");
      end else begin
         exp = exp_store.pop_front();
         assert (mem_wr.addr == exp.addr && mem_wr.data == exp.data) else begin
            if (mem_wr.addr != exp.addr)
               report_mismatch("mem_wr.addr", exp.addr, mem_wr.addr);
            else
               report_mismatch("mem_wr.data", exp.data, mem_wr.data);
         end
      end
   endtask

   always @(posedge clk) begin
      if (retire.valid) begin
         check_retire();
      end
   end

   always @(posedge clk) begin
      if (mem_wr.valid) begin
         check_store();
      end
   end

   // Outputs idle in reset and on the first cycle after
   a_reset_retire: assert property (@(posedge clk) (!rst || !$past(rst)) |-> !retire.valid)
      else report_mismatch("retire.valid", '0, word_t'($sampled(retire.valid)));
   a_reset_mem_wr: assert property (@(posedge clk) (!rst || !$past(rst)) |-> !mem_wr.valid)
      else report_mismatch("mem_wr.valid", '0, word_t'($sampled(mem_wr.valid)));
   a_reset_pc: assert property (@(posedge clk) (!rst || !$past(rst)) |-> pc == `CPU_PC_RESET)
      else report_mismatch("pc", `CPU_PC_RESET, $sampled(pc));

   initial begin
      #(CLK_PERIOD * (RESET_CYCLES + PROG_LEN * CYCLES_PER_INSTR + IDLE_CYCLES));
      report_failure($sformatf("timeout with %0d write-backs and %0d stores still expected",
                               exp_retire.size(), exp_store.size()));
   end

   initial begin
      rst  = 1'b0;
      prog = '0;
      void'($urandom(32'ha076));
      build_program();
      run_model();
      load_program();
      while (exp_retire.size() != 0 || exp_store.size() != 0) begin
         @(posedge clk);
      end
      // Any stray write-back shows up during the idle loop
      repeat (IDLE_CYCLES) @(posedge clk);
      if (exp_retire.size() == 0 && exp_store.size() == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         report_failure("expected events left after the idle period");
      end
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decoder.sv
verilog/stall_detector.sv
verilog/register_file.sv
verilog/stage_exe.sv
verilog/main_memory.sv
verilog/cpu_pipelined_basic.sv
dv/tb_cpu.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_cpu -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^=== PASS ===$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
